// ==== filelist.f ====
logic/ledPkg.sv
logic/ledCsr.sv
logic/dutyGenerator.sv
logic/gpioUnit.sv
logic/ledTop.sv
dv/ledTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = ledTb
FILELIST = filelist.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)
PASS_MSG = Simulation passed

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the list itself changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/ledTb.sv ====
/* Testbench for ledTop: clock, reset, register writes, LFSR stimulus,
   register and pin reference model, checking assertions and watchdog */
`timescale 1ns/1ps

module ledTb
	import ledPkg::*;
();

	localparam int clkPeriod   = 100;
	localparam int resetCycles = 16;
	localparam int blinkRun    = 200;
	localparam int pwmRun      = 3 * 256 + 8;
	// Reads, writes and static rounds take well under 300 cycles
	localparam int planCycles     = resetCycles + 300 + 2 * blinkRun + pwmRun;
	localparam int watchdogCycles = planCycles + 200;

	// Red, green and blue are lit by a low pin
	localparam ledMaskT activeLowPins = 5'b11100;

	logic       iSCLK;
	logic       arstN;
	logic       wrEn;
	csrAddrT    wrAddr;
	csrDataT    wrData;
	csrAddrT    rdAddr;
	csrDataT    rdData;
	logic [1:0] led;
	logic       ledR;
	logic       ledG;
	logic       ledB;

	logic [31:0] lfsrState;

	// Register copy, plus the values one edge old
	ledMaskT     regEn;
	flashModeT   regMode;
	logic [7:0]  regDuty [ledCount];
	logic [15:0] regIv   [ledCount];
	ledMaskT     regEnQ;
	flashModeT   modeQ;
	csrDataT     expRead;
	csrDataT     expReadQ;

	ledMaskT pinNow;
	ledMaskT litNow;

	// Per-LED blink and PWM bookkeeping, updated on the falling edge
	logic [26:0] prevSig   [ledCount];
	logic        prevLit   [ledCount];
	logic        seenFirst [ledCount];
	int          age       [ledCount];
	logic        gapValid  [ledCount];
	int          gapSeen   [ledCount];
	int          gapExp    [ledCount];
	logic        tooLate   [ledCount];
	int          pHigh     [ledCount];
	int          pLen      [ledCount];
	logic        winValid  [ledCount];
	int          winSeen   [ledCount];
	int          winExp    [ledCount];

	ledTop ledTop_inst (
		.iSCLK  (iSCLK),
		.arstN  (arstN),
		.wrEn   (wrEn),
		.wrAddr (wrAddr),
		.wrData (wrData),
		.rdAddr (rdAddr),
		.rdData (rdData),
		.led    (led),
		.ledR   (ledR),
		.ledG   (ledG),
		.ledB   (ledB)
	);

	assign pinNow = {ledB, ledG, ledR, led};
	assign litNow = pinNow ^ activeLowPins;

	initial
	begin
		iSCLK = 1'b0;
		forever #(clkPeriod / 2) iSCLK = ~iSCLK;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first failing check");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic csrDataT takeBits(input int n);
		csrDataT v;
		int      b;
		v = '0;
		for (b = 0; b < n; b++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(negedge iSCLK);
	endtask

	// Called and returns on a falling edge
	task automatic writeReg(input csrAddrT addr, input csrDataT data);
		wrEn   = 1'b1;
		wrAddr = addr;
		wrData = data;
		@(negedge iSCLK);
		wrEn = 1'b0;
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	always @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			regEn    <= '0;
			regMode  <= modeStatic;
			regEnQ   <= '0;
			modeQ    <= modeStatic;
			expReadQ <= '0;
			for (int i = 0; i < ledCount; i++)
			begin
				regDuty[i] <= '0;
				regIv[i]   <= '0;
			end
		end
		else
		begin
			regEnQ   <= regEn;
			modeQ    <= regMode;
			expReadQ <= expRead;
			if (wrEn)
			begin
				if (wrAddr == addrEnable)
					regEn <= wrData[4:0];
				else if (wrAddr == addrMode)
					regMode <= flashModeT'(wrData[1:0]);
				else if (wrAddr >= addrDutyBase && wrAddr < addrIntervalBase)
					regDuty[wrAddr - addrDutyBase] <= wrData[7:0];
				else if (wrAddr >= addrIntervalBase && wrAddr < 4'd12)
					regIv[wrAddr - addrIntervalBase] <= wrData;
			end
		end
	end

	always_comb
	begin
		expRead = '0;
		if (rdAddr == addrEnable)
			expRead = {11'd0, regEn};
		else if (rdAddr == addrMode)
			expRead = {14'd0, regMode};
		else if (rdAddr >= addrDutyBase && rdAddr < addrIntervalBase)
			expRead = {8'd0, regDuty[rdAddr - addrDutyBase]};
		else if (rdAddr >= addrIntervalBase && rdAddr < 4'd12)
			expRead = regIv[rdAddr - addrIntervalBase];
	end

	// Toggle gaps and PWM windows, measured from the settled pins
	always @(negedge iSCLK)
	begin
		logic [26:0] sigNow;
		logic        blinkOn;
		logic        pwmOn;
		for (int i = 0; i < ledCount; i++)
		begin
			sigNow   = {regMode, regEn[i], regDuty[i], regIv[i]};
			blinkOn  = (regMode == modeBlink) && regEn[i];
			pwmOn    = (regMode == modePwm) && regEn[i];
			gapValid[i] = 1'b0;
			winValid[i] = 1'b0;
			tooLate[i]  = 1'b0;
			if (!arstN || sigNow != prevSig[i])
			begin
				prevSig[i]   = sigNow;
				prevLit[i]   = litNow[i];
				seenFirst[i] = 1'b0;
				age[i]       = 0;
				pHigh[i]     = 0;
				pLen[i]      = 0;
			end
			else
			begin
				age[i] = age[i] + 1;
				if (litNow[i] != prevLit[i])
				begin
					// The first toggle after a change only sets the reference
					if (seenFirst[i] && blinkOn)
					begin
						gapValid[i] = 1'b1;
						gapSeen[i]  = age[i];
						gapExp[i]   = int'(regIv[i]) + 1;
					end
					seenFirst[i] = 1'b1;
					age[i]       = 0;
				end
				prevLit[i] = litNow[i];
				tooLate[i] = blinkOn && (age[i] > int'(regIv[i]) + 1);
				if (pwmOn)
				begin
					pHigh[i] = pHigh[i] + int'(litNow[i]);
					pLen[i]  = pLen[i] + 1;
					if (pLen[i] == 256)
					begin
						winValid[i] = 1'b1;
						winSeen[i]  = pHigh[i];
						winExp[i]   = int'(regDuty[i]);
						pHigh[i]    = 0;
						pLen[i]     = 0;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	resetPinsOff: assert property (
		@(posedge iSCLK) !arstN |-> (litNow == '0 && rdData == '0)
	) else failRun("Pins or read data not cleared while reset is held");

	readback: assert property (
		@(posedge iSCLK) disable iff (!arstN) rdData == expReadQ
	) else failRun($sformatf("MISMATCH time=%0t signal=rdData expected=%h actual=%h",
		$time, $sampled(expReadQ), $sampled(rdData)));

	staticPins: assert property (
		@(posedge iSCLK) disable iff (!arstN)
		(modeQ == modeStatic || modeQ == modeReserved) |->
			pinNow == (regEnQ ^ activeLowPins)
	) else failRun($sformatf("MISMATCH time=%0t signal={ledB,ledG,ledR,led} expected=%b actual=%b",
		$time, $sampled(regEnQ ^ activeLowPins), $sampled(pinNow)));

	for (genvar i = 0; i < ledCount; i++)
	begin : chkLed
		disabledOff: assert property (
			@(posedge iSCLK) disable iff (!arstN) !regEnQ[i] |-> !litNow[i]
		) else failRun($sformatf("LED %0d is lit although it is disabled", i));

		blinkGap: assert property (
			@(posedge iSCLK) disable iff (!arstN) gapValid[i] |-> gapSeen[i] == gapExp[i]
		) else failRun($sformatf("MISMATCH time=%0t signal=blinkGap[%0d] expected=%0d actual=%0d",
			$time, i, $sampled(gapExp[i]), $sampled(gapSeen[i])));

		blinkLate: assert property (
			@(posedge iSCLK) disable iff (!arstN) !tooLate[i]
		) else failRun($sformatf("LED %0d missed its blink toggle", i));

		pwmWindow: assert property (
			@(posedge iSCLK) disable iff (!arstN) winValid[i] |-> winSeen[i] == winExp[i]
		) else failRun($sformatf("MISMATCH time=%0t signal=pwmHigh[%0d] expected=%0d actual=%0d",
			$time, i, $sampled(winExp[i]), $sampled(winSeen[i])));
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial
	begin
		csrDataT r;
		wrEn      = 1'b0;
		wrAddr    = '0;
		wrData    = '0;
		rdAddr    = '0;
		arstN     = 1'b0;
		lfsrState = 32'h2c94_8319;
		waitCycles(resetCycles);
		arstN = 1'b1;

		// Every address reads zero after reset
		for (int a = 0; a < 16; a++)
		begin
			rdAddr = csrAddrT'(a);
			waitCycles(1);
		end

		// Random fill, unused addresses included, then read back
		for (int a = 0; a < 16; a++)
			writeReg(csrAddrT'(a), takeBits(16));
		for (int a = 0; a < 16; a++)
		begin
			rdAddr = csrAddrT'(a);
			waitCycles(2);
		end

		// Static, then the reserved mode value
		writeReg(addrEnable, '0);
		for (int m = 0; m < 4; m += 3)
		begin
			writeReg(addrMode, csrDataT'(m));
			repeat (6)
			begin
				writeReg(addrEnable, takeBits(5));
				waitCycles(3);
			end
		end

		// Blink with small intervals, then swap the enabled set
		writeReg(addrEnable, '0);
		writeReg(addrMode, csrDataT'(modeBlink));
		for (int i = 0; i < ledCount; i++)
			writeReg(csrAddrT'(addrIntervalBase + i), takeBits(4));
		r = takeBits(5);
		writeReg(addrEnable, r);
		waitCycles(blinkRun);
		writeReg(addrEnable, {11'd0, ~r[4:0]});
		waitCycles(blinkRun);

		// PWM including both duty extremes
		writeReg(addrEnable, '0);
		writeReg(addrMode, csrDataT'(modePwm));
		writeReg(addrDutyBase, 16'd0);
		writeReg(csrAddrT'(addrDutyBase + 1), 16'd255);
		for (int i = 2; i < ledCount; i++)
			writeReg(csrAddrT'(addrDutyBase + i), takeBits(8));
		writeReg(addrEnable, 16'h001f);
		waitCycles(pwmRun);

		waitCycles(4);
		$display("Simulation passed");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		failRun("Watchdog expired before the tests finished");
	end

endmodule

// ==== logic/ledTop.sv ====
/* Top level: register block driving the GPIO unit */
`timescale 1ns/1ps

module ledTop
	import ledPkg::*;
#(
	parameter int dutyWidth = 8,
	parameter int ivWidth   = 16
)(
	input  logic       iSCLK,
	input  logic       arstN,
	input  logic       wrEn,
	input  csrAddrT    wrAddr,
	input  csrDataT    wrData,
	input  csrAddrT    rdAddr,
	output csrDataT    rdData,
	output logic [1:0] led,
	output logic       ledR,
	output logic       ledG,
	output logic       ledB
);

	ledMaskT              gpioEn;
	flashModeT            flashMode;
	logic [dutyWidth-1:0] dutyRatio0;
	logic [dutyWidth-1:0] dutyRatio1;
	logic [dutyWidth-1:0] dutyRatio2;
	logic [dutyWidth-1:0] dutyRatio3;
	logic [dutyWidth-1:0] dutyRatio4;
	logic [ivWidth-1:0]   ivTimer0;
	logic [ivWidth-1:0]   ivTimer1;
	logic [ivWidth-1:0]   ivTimer2;
	logic [ivWidth-1:0]   ivTimer3;
	logic [ivWidth-1:0]   ivTimer4;

	ledCsr #(
		.dutyWidth (dutyWidth),
		.ivWidth   (ivWidth)
	) ledCsr_inst (
		.iSCLK      (iSCLK),
		.arstN      (arstN),
		.wrEn       (wrEn),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.rdAddr     (rdAddr),
		.rdData     (rdData),
		.gpioEn     (gpioEn),
		.flashMode  (flashMode),
		.dutyRatio0 (dutyRatio0),
		.dutyRatio1 (dutyRatio1),
		.dutyRatio2 (dutyRatio2),
		.dutyRatio3 (dutyRatio3),
		.dutyRatio4 (dutyRatio4),
		.ivTimer0   (ivTimer0),
		.ivTimer1   (ivTimer1),
		.ivTimer2   (ivTimer2),
		.ivTimer3   (ivTimer3),
		.ivTimer4   (ivTimer4)
	);

	gpioUnit #(
		.dutyWidth (dutyWidth),
		.ivWidth   (ivWidth)
	) gpioUnit_inst (
		.iSCLK      (iSCLK),
		.arstN      (arstN),
		.gpioEn     (gpioEn),
		.flashMode  (flashMode),
		.dutyRatio0 (dutyRatio0),
		.dutyRatio1 (dutyRatio1),
		.dutyRatio2 (dutyRatio2),
		.dutyRatio3 (dutyRatio3),
		.dutyRatio4 (dutyRatio4),
		.ivTimer0   (ivTimer0),
		.ivTimer1   (ivTimer1),
		.ivTimer2   (ivTimer2),
		.ivTimer3   (ivTimer3),
		.ivTimer4   (ivTimer4),
		.led        (led),
		.ledR       (ledR),
		.ledG       (ledG),
		.ledB       (ledB)
	);

endmodule

// ==== logic/gpioUnit.sv ====
/* GPIO unit: five duty generators, flash-mode selection,
   RGB polarity and the registered pin levels */
`timescale 1ns/1ps

module gpioUnit
	import ledPkg::*;
#(
	parameter int dutyWidth = 8,
	parameter int ivWidth   = 16
)(
	input  logic                 iSCLK,
	input  logic                 arstN,
	input  ledMaskT              gpioEn,
	input  flashModeT            flashMode,
	input  logic [dutyWidth-1:0] dutyRatio0,
	input  logic [dutyWidth-1:0] dutyRatio1,
	input  logic [dutyWidth-1:0] dutyRatio2,
	input  logic [dutyWidth-1:0] dutyRatio3,
	input  logic [dutyWidth-1:0] dutyRatio4,
	input  logic [ivWidth-1:0]   ivTimer0,
	input  logic [ivWidth-1:0]   ivTimer1,
	input  logic [ivWidth-1:0]   ivTimer2,
	input  logic [ivWidth-1:0]   ivTimer3,
	input  logic [ivWidth-1:0]   ivTimer4,
	output logic [1:0]           led,
	output logic                 ledR,
	output logic                 ledG,
	output logic                 ledB
);

	logic [dutyWidth-1:0] dutyArr [ledCount];
	logic [ivWidth-1:0]   ivArr   [ledCount];
	ledMaskT              pwmEn;
	ledMaskT              pwm;
	ledMaskT              ivCke;
	ledMaskT              litNext;
	ledMaskT              litQ;
	ledMaskT              pinLevel;

	assign dutyArr[0] = dutyRatio0;
	assign dutyArr[1] = dutyRatio1;
	assign dutyArr[2] = dutyRatio2;
	assign dutyArr[3] = dutyRatio3;
	assign dutyArr[4] = dutyRatio4;

	assign ivArr[0] = ivTimer0;
	assign ivArr[1] = ivTimer1;
	assign ivArr[2] = ivTimer2;
	assign ivArr[3] = ivTimer3;
	assign ivArr[4] = ivTimer4;

	// ----------------------------------------
	// Per-LED timing
	// ----------------------------------------
	for (genvar i = 0; i < ledCount; i++)
	begin : genLed
		// Counters only run in blink and PWM modes
		assign pwmEn[i] = gpioEn[i] &
			((flashMode == modeBlink) | (flashMode == modePwm));

		dutyGenerator #(
			.dutyWidth (dutyWidth),
			.ivWidth   (ivWidth)
		) dutyGen_inst (
			.iSCLK     (iSCLK),
			.arstN     (arstN),
			.pwmEn     (pwmEn[i]),
			.dutyRatio (dutyArr[i]),
			.ivTimer   (ivArr[i]),
			.pwm       (pwm[i]),
			.ivCke     (ivCke[i])
		);

		// Pin must read as off right after a disable, in any mode
		offAfterDisable: assert property (
			@(posedge iSCLK) disable iff (!arstN)
			!gpioEn[i] |=> (pinLevel[i] == rgbActiveLowMask[i])
		);
	end

	// ----------------------------------------
	// Mode selection
	// ----------------------------------------
	always_comb
	begin
		case (flashMode)
			modeBlink:
				litNext = (litQ ^ ivCke) & gpioEn;
			modePwm:
				litNext = pwm;
			modeStatic, modeReserved:
				litNext = gpioEn;
		endcase
	end

	// Active-high lit state, one flop per pin
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			litQ <= '0;
		else
			litQ <= litNext;
	end

	// Same polarity handling in every mode
	assign pinLevel = litQ ^ rgbActiveLowMask;

	assign led  = pinLevel[1:0];
	assign ledR = pinLevel[2];
	assign ledG = pinLevel[3];
	assign ledB = pinLevel[4];

endmodule

// ==== logic/dutyGenerator.sv ====
/* Per-LED interval timer and free-running PWM comparator */
`timescale 1ns/1ps

module dutyGenerator
	import ledPkg::*;
#(
	parameter int dutyWidth = 8,
	parameter int ivWidth   = 16
)(
	input  logic                 iSCLK,
	input  logic                 arstN,
	input  logic                 pwmEn,
	input  logic [dutyWidth-1:0] dutyRatio,
	input  logic [ivWidth-1:0]   ivTimer,
	output logic                 pwm,
	output logic                 ivCke
);

	logic [ivWidth-1:0]   ivCnt;
	logic [dutyWidth-1:0] pwmCnt;
	logic                 ivHit;

	// ----------------------------------------
	// Interval timer
	// ----------------------------------------
	// Period is ivTimer+1 cycles.
	// Compare is >= so a shortened interval restarts at once
	// instead of running the counter all the way round
	assign ivHit = (ivCnt >= ivTimer);

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			ivCnt <= '0;
		else if (!pwmEn || ivHit)
			ivCnt <= '0;
		else
			ivCnt <= ivCnt + 1'b1;
	end

	assign ivCke = pwmEn & ivHit;

	// ----------------------------------------
	// PWM
	// ----------------------------------------
	// Wraps naturally at 2^dutyWidth
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			pwmCnt <= '0;
		else if (!pwmEn)
			pwmCnt <= '0;
		else
			pwmCnt <= pwmCnt + 1'b1;
	end

	// dutyRatio high cycles per window
	assign pwm = pwmEn & (pwmCnt < dutyRatio);

	// Counter never passes a steady interval setting
	ivCntInRange: assert property (
		@(posedge iSCLK) disable iff (!arstN)
		$stable(ivTimer) |-> ivCnt <= ivTimer
	);

endmodule

// ==== logic/ledCsr.sv ====
/* Register block: strobe-written LED settings with
   reset to zero and one-cycle registered readback */
`timescale 1ns/1ps

module ledCsr
	import ledPkg::*;
#(
	parameter int dutyWidth = 8,
	parameter int ivWidth   = 16
)(
	input  logic                 iSCLK,
	input  logic                 arstN,
	// Register port
	input  logic                 wrEn,
	input  csrAddrT              wrAddr,
	input  csrDataT              wrData,
	input  csrAddrT              rdAddr,
	output csrDataT              rdData,
	// Settings towards the GPIO unit
	output ledMaskT              gpioEn,
	output flashModeT            flashMode,
	output logic [dutyWidth-1:0] dutyRatio0,
	output logic [dutyWidth-1:0] dutyRatio1,
	output logic [dutyWidth-1:0] dutyRatio2,
	output logic [dutyWidth-1:0] dutyRatio3,
	output logic [dutyWidth-1:0] dutyRatio4,
	output logic [ivWidth-1:0]   ivTimer0,
	output logic [ivWidth-1:0]   ivTimer1,
	output logic [ivWidth-1:0]   ivTimer2,
	output logic [ivWidth-1:0]   ivTimer3,
	output logic [ivWidth-1:0]   ivTimer4
);

	logic [dutyWidth-1:0] dutyReg [ledCount];
	logic [ivWidth-1:0]   ivReg   [ledCount];
	csrDataT              rdNext;

	// ----------------------------------------
	// Write decode
	// ----------------------------------------
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			gpioEn    <= '0;
			flashMode <= modeStatic;
			for (int i = 0; i < ledCount; i++)
			begin
				dutyReg[i] <= '0;
				ivReg[i]   <= '0;
			end
		end
		else if (wrEn)
		begin
			if (wrAddr == addrEnable)
				gpioEn <= wrData[ledCount-1:0];
			if (wrAddr == addrMode)
				flashMode <= flashModeT'(wrData[1:0]);
			// Per-LED banks, data cut to the register width
			for (int i = 0; i < ledCount; i++)
			begin
				if (wrAddr == csrAddrT'(addrDutyBase + i))
					dutyReg[i] <= wrData[dutyWidth-1:0];
				if (wrAddr == csrAddrT'(addrIntervalBase + i))
					ivReg[i] <= wrData[ivWidth-1:0];
			end
		end
	end

	assign dutyRatio0 = dutyReg[0];
	assign dutyRatio1 = dutyReg[1];
	assign dutyRatio2 = dutyReg[2];
	assign dutyRatio3 = dutyReg[3];
	assign dutyRatio4 = dutyReg[4];

	assign ivTimer0 = ivReg[0];
	assign ivTimer1 = ivReg[1];
	assign ivTimer2 = ivReg[2];
	assign ivTimer3 = ivReg[3];
	assign ivTimer4 = ivReg[4];

	// ----------------------------------------
	// Readback
	// ----------------------------------------
	// Unmapped addresses fall through as zero
	always_comb
	begin
		rdNext = '0;
		if (rdAddr == addrEnable)
			rdNext = csrDataT'(gpioEn);
		if (rdAddr == addrMode)
			rdNext = csrDataT'(flashMode);
		for (int i = 0; i < ledCount; i++)
		begin
			if (rdAddr == csrAddrT'(addrDutyBase + i))
				rdNext = csrDataT'(dutyReg[i]);
			if (rdAddr == csrAddrT'(addrIntervalBase + i))
				rdNext = csrDataT'(ivReg[i]);
		end
	end

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			rdData <= '0;
		else
			rdData <= rdNext;
	end

	// An unknown address would corrupt an arbitrary register
	wrAddrKnown: assert property (
		@(posedge iSCLK) disable iff (!arstN)
		wrEn |-> !$isunknown(wrAddr)
	);

endmodule

// ==== logic/ledPkg.sv ====
/* LED count, RGB polarity mask, register address map,
   vector typedefs and the flash-mode encoding */

package ledPkg;

	// Two discrete LEDs, then red, green, blue
	localparam int ledCount = 5;

	// RGB pins sink current, so lit means low
	localparam logic [ledCount-1:0] rgbActiveLowMask = 5'b11100;

	// ----------------------------------------
	// Vector types
	// ----------------------------------------
	typedef logic [3:0]          csrAddrT;
	typedef logic [15:0]         csrDataT;
	typedef logic [ledCount-1:0] ledMaskT;

	typedef enum logic [1:0]
	{
		modeStatic   = 2'd0,
		modeBlink    = 2'd1,
		modePwm      = 2'd2,
		modeReserved = 2'd3
	} flashModeT;

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	// Enable bits in [4:0]
	localparam csrAddrT addrEnable       = 4'd0;
	// Flash mode in [1:0]
	localparam csrAddrT addrMode         = 4'd1;
	// One duty register per LED, 2..6
	localparam csrAddrT addrDutyBase     = 4'd2;
	// One interval register per LED, 7..11
	localparam csrAddrT addrIntervalBase = 4'd7;
	// 12..15 unmapped, read as zero

endpackage
